// File: hw/sram_defines.svh
`ifndef SRAM_DEFINES_SVH
`define SRAM_DEFINES_SVH

// external sram geometry.
`define SRAM_ADDR_BITS 18
`define SRAM_INDEX_BITS 16

// processor side byte address.
`define MEM_ADDR_BITS 32

// clock cycles spent on each half-word phase.
`define SRAM_WAIT_DEFAULT 2

`endif

// File: hw/sram_pkg.sv
package sram_pkg;

    // processor memory port.
    typedef logic [31:0] mem_addr_t;    // byte address.
    typedef logic [63:0] mem_data_t;
    typedef logic [7:0]  mem_strb_t;    // one bit per byte.

    // 64-bit word index, byte address bits 18..3.
    typedef logic [15:0] word_index_t;

    // sram side, {word index, half number}.
    typedef logic [17:0] sram_addr_t;
    typedef logic [15:0] sram_data_t;
    typedef logic [1:0]  half_index_t;

    typedef enum logic [1:0] {
        idle,
        phase,
        finish
    } phase_state_t;

endpackage

// File: hw/sram_request_decode.sv
`timescale 1ns/10ps
`include "sram_defines.svh"

module sram_request_decode import sram_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        mem_valid,
    input  mem_addr_t   mem_addr,
    input  mem_data_t   mem_wdata,
    input  mem_strb_t   mem_wstrb,
    input  logic        op_done,
    output logic        cmd_start,
    output logic        cmd_error,
    output logic        cmd_write,
    output word_index_t cmd_index,
    output mem_data_t   cmd_wdata,
    output mem_strb_t   cmd_wstrb
);

    logic busy;
    logic error_pending;
    logic accept;
    logic in_range;

    assign accept = mem_valid && !busy;

    // nothing above the 512 KB window may reach the pins.
    assign in_range = (mem_addr[`MEM_ADDR_BITS-1:`SRAM_ADDR_BITS+1] == '0);

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
            error_pending <= 1'b0;
            cmd_start <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            cmd_start <= accept && in_range;
            error_pending <= accept && !in_range;
            cmd_error <= error_pending;    // reported a cycle after accept.
            if (accept) begin
                busy <= 1'b1;
            end else if (op_done || cmd_error) begin
                busy <= 1'b0;
            end
        end
    end

    // command fields stay put until the next accept.
    always_ff @(posedge clock) begin
        if (accept) begin
            cmd_write <= |mem_wstrb;    // no strobes means read.
            cmd_index <= mem_addr[`SRAM_INDEX_BITS+2:3];
            cmd_wdata <= mem_wdata;
            cmd_wstrb <= mem_wstrb;
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        !(cmd_start && cmd_error));

endmodule

// File: hw/sram_phase_sequencer.sv
`timescale 1ns/10ps
`include "sram_defines.svh"

module sram_phase_sequencer import sram_pkg::*; #(
    parameter int wait_cycles = `SRAM_WAIT_DEFAULT
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        cmd_start,
    input  logic        cmd_write,
    input  word_index_t cmd_index,
    input  mem_data_t   cmd_wdata,
    input  mem_strb_t   cmd_wstrb,
    output logic        half_capture,
    output half_index_t half_sel,
    output sram_data_t  read_half,
    output logic        op_done,
    output logic        sram_ce_n,
    output logic        sram_we_n,
    output logic        sram_oe_n,
    output logic        sram_ub_n,
    output logic        sram_lb_n,
    output sram_addr_t  sram_addr,
    inout  sram_data_t  sram_dq
);

    localparam int half_bits = `SRAM_ADDR_BITS - `SRAM_INDEX_BITS;
    localparam half_index_t last_half = half_index_t'((1 << half_bits) - 1);
    localparam int count_bits = (wait_cycles > 1) ? $clog2(wait_cycles) : 1;
    localparam logic [count_bits-1:0] last_count = count_bits'(wait_cycles - 1);

    phase_state_t          state;
    logic [count_bits-1:0] count;
    half_index_t           half;
    logic [4:0]            pins_q;    // {ce, we, oe, ub, lb}, all active low.
    sram_data_t            dq_q;
    sram_addr_t            addr_q;
    logic                  start_phase;
    logic                  phase_end;
    logic                  advance;
    half_index_t           load_half;

    // control pins for one half-word phase.
    function automatic logic [4:0] phase_pins(input logic write, input half_index_t h,
                                              input mem_strb_t strb);
        logic [1:0] lanes;
        lanes = strb[{h, 1'b0} +: 2];
        if (write) begin
            phase_pins = {~|lanes, ~|lanes, 1'b1, ~lanes[1], ~lanes[0]};
        end else begin
            phase_pins = 5'b01000;
        end
    endfunction

    assign start_phase = (state == idle) && cmd_start;
    assign phase_end = (state == phase) && (count == last_count);
    assign advance = phase_end && (half != last_half);
    assign load_half = start_phase ? half_index_t'(0) : half + 2'd1;

    // ============================================================
    // phase stepping
    // ============================================================
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            count <= '0;
            half <= '0;
            pins_q <= 5'b11111;
        end else begin
            case (state)
                idle: begin
                    if (cmd_start) begin
                        state <= phase;
                        count <= '0;
                        half <= '0;
                    end
                end
                phase: begin
                    if (count == last_count) begin
                        count <= '0;
                        half <= load_half;
                        if (half == last_half) begin
                            state <= finish;
                        end
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: state <= idle;    // finish lasts one cycle.
            endcase
            if (start_phase || advance) begin
                pins_q <= phase_pins(cmd_write, load_half, cmd_wstrb);
            end else if (phase_end) begin
                pins_q <= 5'b11111;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start_phase || advance) begin
            dq_q <= cmd_wdata[{load_half, 4'b0000} +: 16];
            addr_q <= {cmd_index, load_half};
        end
    end

    // ============================================================
    // pins and result side
    // ============================================================
    assign {sram_ce_n, sram_we_n, sram_oe_n, sram_ub_n, sram_lb_n} = pins_q;
    assign sram_addr = addr_q;
    assign sram_dq = sram_we_n ? 'z : dq_q;    // driven only while writing.

    assign read_half = sram_dq;
    assign half_sel = half;
    assign half_capture = phase_end && !cmd_write;    // last cycle of a read phase.
    assign op_done = (state == finish);

    assert property (@(posedge clock) disable iff (!reset)
        sram_we_n || sram_oe_n);

    assert property (@(posedge clock) disable iff (!reset)
        (state == idle) |-> (pins_q == 5'b11111));

endmodule

// File: hw/sram_read_assemble.sv
`timescale 1ns/10ps

module sram_read_assemble import sram_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        half_capture,
    input  half_index_t half_sel,
    input  sram_data_t  read_half,
    input  logic        op_done,
    input  logic        cmd_error,
    output logic        mem_ready,
    output logic        mem_error,
    output mem_data_t   mem_rdata
);

    always_ff @(posedge clock) begin
        if (!reset) begin
            mem_ready <= 1'b0;
            mem_error <= 1'b0;
        end else begin
            mem_ready <= op_done || cmd_error;
            mem_error <= cmd_error;
        end
    end

    // half n lands in bits 16n+15..16n.
    always_ff @(posedge clock) begin
        if (!reset) begin
            mem_rdata <= '0;
        end else if (mem_ready) begin
            mem_rdata <= '0;    // writes and errors answer zero.
        end else if (half_capture) begin
            mem_rdata[{half_sel, 4'b0000} +: 16] <= read_half;
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        mem_ready |=> !mem_ready);

endmodule

// File: hw/sram_controller.sv
`timescale 1ns/10ps
`include "sram_defines.svh"

module sram_controller import sram_pkg::*; #(
    parameter int wait_cycles = `SRAM_WAIT_DEFAULT
) (
    input  logic       clock,
    input  logic       reset,
    // ============================================================
    // processor memory port
    // ============================================================
    input  logic       mem_valid,
    input  mem_addr_t  mem_addr,
    input  mem_data_t  mem_wdata,
    input  mem_strb_t  mem_wstrb,
    output logic       mem_ready,
    output logic       mem_error,
    output mem_data_t  mem_rdata,
    // ============================================================
    // external sram
    // ============================================================
    output logic       sram_ce_n,
    output logic       sram_we_n,
    output logic       sram_oe_n,
    output logic       sram_ub_n,
    output logic       sram_lb_n,
    output sram_addr_t sram_addr,
    inout  sram_data_t sram_dq
);

    logic        cmd_start;
    logic        cmd_error;
    logic        cmd_write;
    word_index_t cmd_index;
    mem_data_t   cmd_wdata;
    mem_strb_t   cmd_wstrb;
    logic        half_capture;
    half_index_t half_sel;
    sram_data_t  read_half;
    logic        op_done;    // also frees decode.

    sram_request_decode request_decode_inst (
        .clock     (clock),
        .reset     (reset),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .op_done   (op_done),
        .cmd_start (cmd_start),
        .cmd_error (cmd_error),
        .cmd_write (cmd_write),
        .cmd_index (cmd_index),
        .cmd_wdata (cmd_wdata),
        .cmd_wstrb (cmd_wstrb)
    );

    sram_phase_sequencer #(
        .wait_cycles (wait_cycles)
    ) phase_sequencer_inst (
        .clock        (clock),
        .reset        (reset),
        .cmd_start    (cmd_start),
        .cmd_write    (cmd_write),
        .cmd_index    (cmd_index),
        .cmd_wdata    (cmd_wdata),
        .cmd_wstrb    (cmd_wstrb),
        .half_capture (half_capture),
        .half_sel     (half_sel),
        .read_half    (read_half),
        .op_done      (op_done),
        .sram_ce_n    (sram_ce_n),
        .sram_we_n    (sram_we_n),
        .sram_oe_n    (sram_oe_n),
        .sram_ub_n    (sram_ub_n),
        .sram_lb_n    (sram_lb_n),
        .sram_addr    (sram_addr),
        .sram_dq      (sram_dq)
    );

    sram_read_assemble read_assemble_inst (
        .clock        (clock),
        .reset        (reset),
        .half_capture (half_capture),
        .half_sel     (half_sel),
        .read_half    (read_half),
        .op_done      (op_done),
        .cmd_error    (cmd_error),
        .mem_ready    (mem_ready),
        .mem_error    (mem_error),
        .mem_rdata    (mem_rdata)
    );

endmodule

// File: bench/sram_chip_model.sv
`timescale 1ns/10ps

module sram_chip_model import sram_pkg::*; (
    input  logic       sram_ce_n,
    input  logic       sram_we_n,
    input  logic       sram_oe_n,
    input  logic       sram_ub_n,
    input  logic       sram_lb_n,
    input  sram_addr_t sram_addr,
    inout  sram_data_t sram_dq
);

    sram_data_t cells [0:(1 << 18) - 1];

    // each cell starts as its word index mixed with its half number.
    initial begin
        for (int a = 0; a < (1 << 18); a++) begin
            cells[a] = sram_data_t'(a >> 2) ^ {2'(a), 14'h1c35};
        end
    end

    assign sram_dq = (!sram_ce_n && !sram_oe_n && sram_we_n) ? cells[sram_addr] : 'z;

    // writes land once the pins have settled after a change.
    always @(sram_ce_n or sram_we_n or sram_ub_n or sram_lb_n or sram_addr or sram_dq) begin
        #1;
        if (!sram_ce_n && !sram_we_n) begin
            if (!sram_ub_n) cells[sram_addr][15:8] = sram_dq[15:8];
            if (!sram_lb_n) cells[sram_addr][7:0] = sram_dq[7:0];
        end
    end

endmodule

// File: bench/sram_checker.sv
`timescale 1ns/10ps

module sram_checker import sram_pkg::*; #(
    parameter int wait_cycles = 2
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       mem_valid,
    input  mem_addr_t  mem_addr,
    input  mem_data_t  mem_wdata,
    input  mem_strb_t  mem_wstrb,
    input  logic       mem_ready,
    input  logic       mem_error,
    input  mem_data_t  mem_rdata,
    input  logic       sram_ce_n,
    input  logic       sram_we_n,
    input  logic       sram_oe_n,
    input  logic       sram_ub_n,
    input  logic       sram_lb_n,
    input  sram_addr_t sram_addr,
    output int         error_count,
    output int         pin_errors
);

    mem_data_t ref_mem [0:65535];    // one entry per 64-bit word.
    logic      pending = 1'b0;
    logic      ready_last = 1'b0;
    logic      req_ok;
    mem_addr_t req_addr;
    mem_data_t req_wdata;
    mem_strb_t req_wstrb;
    int        cycle = 0;
    int        accept_cycle = 0;
    int        settle = 2;
    int        value_errors = 0;
    int        idle_errors = 0;

    initial begin
        pin_errors = 0;
        for (int i = 0; i < 65536; i++) begin
            for (int h = 0; h < 4; h++) begin
                ref_mem[i][h*16 +: 16] = sram_data_t'(i) ^ {2'(h), 14'h1c35};
            end
        end
    end

    // ============================================================
    // request tracking, sampled on the rising edge
    // ============================================================
    always @(posedge clock) begin
        int          latency;
        int          expected_latency;
        mem_data_t   expected;
        half_index_t half;
        logic [1:0]  lanes_n;
        if (!reset) begin
            pending = 1'b0;
            ready_last = 1'b0;
        end else begin
            cycle++;
            if (mem_ready && ready_last) begin
                value_errors++;
                $display("at %0t mem_ready stayed high for a second cycle", $time);
            end
            if (pending && !req_ok && !sram_ce_n) begin
                value_errors++;
                $display("at %0t sram_ce_n went low for an out-of-range request", $time);
            end
            if (pending && req_ok && !sram_ce_n) begin
                half = sram_addr[1:0];
                // reads open both lanes, writes only the strobed bytes of the half.
                lanes_n = (req_wstrb == '0) ? 2'b00 : ~req_wstrb[half*2 +: 2];
                if (sram_addr[17:2] != req_addr[18:3] || {sram_ub_n, sram_lb_n} != lanes_n) begin
                    value_errors++;
                    $display("MISMATCH at %0t: sram_addr %h lanes %b, expected word %h lanes %b",
                             $time, sram_addr, {sram_ub_n, sram_lb_n}, req_addr[18:3], lanes_n);
                end
            end
            if (mem_ready && !pending) begin
                value_errors++;
                $display("at %0t mem_ready came with no request outstanding", $time);
            end else if (mem_ready) begin
                latency = cycle - accept_cycle - 1;
                expected_latency = req_ok ? 4 * wait_cycles + 2 : 2;
                expected = (req_ok && req_wstrb == '0) ? ref_mem[req_addr[18:3]] : '0;
                if (latency != expected_latency) begin
                    value_errors++;
                    $display("MISMATCH at %0t: latency %0d cycles, expected %0d",
                             $time, latency, expected_latency);
                end
                if (mem_error == req_ok || mem_rdata != expected) begin
                    value_errors++;
                    $display("MISMATCH at %0t: addr %h gave error %b data %h, expected %b %h",
                             $time, req_addr, mem_error, mem_rdata, !req_ok, expected);
                end
                if (req_ok) begin
                    for (int b = 0; b < 8; b++) begin
                        if (req_wstrb[b]) ref_mem[req_addr[18:3]][b*8 +: 8] = req_wdata[b*8 +: 8];
                    end
                end
                pending = 1'b0;
            end
            ready_last = mem_ready;
            if (!pending && mem_valid) begin    // decode takes it on this edge.
                pending = 1'b1;
                accept_cycle = cycle;
                req_ok = (mem_addr[31:19] == '0);
                req_addr = mem_addr;
                req_wdata = mem_wdata;
                req_wstrb = mem_wstrb;
            end
        end
    end

    // pins mid-cycle, and the quiet state around reset.
    always @(negedge clock) begin
        if (!sram_we_n && !sram_oe_n) begin
            pin_errors++;
            $display("at %0t sram_we_n and sram_oe_n are both low", $time);
        end
        if (!reset || settle > 0) begin
            if (mem_ready || mem_error ||
                {sram_ce_n, sram_we_n, sram_oe_n, sram_ub_n, sram_lb_n} != 5'b11111) begin
                idle_errors++;
                $display("MISMATCH at %0t: ready %b error %b pins %b near reset, expected 0 0 11111",
                         $time, mem_ready, mem_error,
                         {sram_ce_n, sram_we_n, sram_oe_n, sram_ub_n, sram_lb_n});
            end
        end
        if (!reset) settle = 2;
        else if (settle > 0) settle--;
    end

    assign error_count = value_errors + idle_errors + pin_errors;

endmodule

// File: bench/sram_controller_tb.sv
`timescale 1ns/10ps

module sram_controller_tb import sram_pkg::*; ();

    localparam int wait_cycles = 3;
    localparam int reset_cycles = 8;
    localparam int full_count = 20;    // write and read pairs.
    localparam int partial_count = 30;
    localparam int range_count = 8;
    localparam int mixed_count = 12;
    localparam int cycle_limit = (full_count + partial_count + range_count + mixed_count)
                                 * (4 * wait_cycles + 6) + reset_cycles;

    logic        clock;
    logic        reset;
    logic        mem_valid;
    mem_addr_t   mem_addr;
    mem_data_t   mem_wdata;
    mem_strb_t   mem_wstrb;
    logic        mem_ready;
    logic        mem_error;
    mem_data_t   mem_rdata;
    logic        sram_ce_n;
    logic        sram_we_n;
    logic        sram_oe_n;
    logic        sram_ub_n;
    logic        sram_lb_n;
    sram_addr_t  sram_addr;
    wire [15:0]  sram_dq;
    int          error_count;
    int          pin_errors;
    int          seed = 32'h28f74f53;
    int          cycles = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          errors_before = 0;
    word_index_t hot_index [8] = '{16'h0000, 16'h0001, 16'h0002, 16'h00ff,
                                   16'h1234, 16'h8000, 16'hfffe, 16'hffff};

    sram_controller #(.wait_cycles(wait_cycles)) sram_controller_inst (.*);
    sram_chip_model chip_inst (.*);
    sram_checker #(.wait_cycles(wait_cycles)) checker_inst (.*);

    always #10 clock = ~clock;

    task automatic do_request(input mem_addr_t addr, input mem_data_t data,
                              input mem_strb_t strb);
        @(negedge clock);
        mem_valid = 1'b1;
        mem_addr = addr;
        mem_wdata = data;
        mem_wstrb = strb;
        @(negedge clock);
        while (!mem_ready) @(negedge clock);
        mem_valid = 1'b0;    // dropped inside the ready cycle.
    endtask

    // mostly a handful of words, so reads hit earlier writes.
    task automatic hot_addr(output mem_addr_t addr);
        int r;
        r = $random(seed);
        if (r[6:4] == 3'b000) addr = {13'h0000, r[23:8], r[2:0]};
        else addr = {13'h0000, hot_index[r[10:8]], r[2:0]};
    endtask

    task automatic far_addr(output mem_addr_t addr);
        int shift;
        shift = 19 + int'($unsigned($random(seed)) % 13);
        addr = $random(seed) | (32'h1 << shift);
    endtask

    task automatic report_test(input string name, input int count);
        int errors;
        @(negedge clock);    // checker scores the last reply on the edge before.
        errors = error_count - errors_before;
        errors_before = error_count;
        if (errors == 0) tests_passed++;
        else tests_failed++;
        $display("%s: %0d requests, %0d errors", name, count, errors);
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        mem_addr_t addr;
        int        r;
        clock = 1'b0;
        reset = 1'b0;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        repeat (2) @(negedge clock);
        report_test("test 1 reset state", 0);

        for (int i = 0; i < full_count / 2; i++) begin
            hot_addr(addr);
            do_request(addr, {$random(seed), $random(seed)}, 8'hff);
            do_request(addr, 64'h0, 8'h00);
        end
        report_test("test 2 full write then read", full_count);

        for (int i = 0; i < partial_count; i++) begin
            hot_addr(addr);
            r = $random(seed);
            do_request(addr, {$random(seed), $random(seed)}, (r[1:0] == 2'b00) ? 8'h00 : r[15:8]);
        end
        report_test("test 3 partial writes", partial_count);

        for (int i = 0; i < range_count; i++) begin
            far_addr(addr);
            r = $random(seed);
            do_request(addr, {r, ~r}, r[7:0]);
        end
        report_test("test 4 out of range", range_count);

        for (int i = 0; i < mixed_count; i++) begin    // latency over both kinds.
            if (i % 2 == 0) hot_addr(addr);
            else far_addr(addr);
            r = $random(seed);
            do_request(addr, {$random(seed), r}, r[0] ? r[15:8] : 8'h00);
        end
        report_test("test 5 latency", mixed_count);

        if (pin_errors == 0) tests_passed++;
        else tests_failed++;
        $display("test 6 we_n and oe_n overlap: %0d cycles seen", pin_errors);

        $display("tests: %0d passed, %0d failed, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: the run did not end within %0d cycles", cycle_limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/sram_pkg.sv
hw/sram_request_decode.sv
hw/sram_phase_sequencer.sv
hw/sram_read_assemble.sv
hw/sram_controller.sv
bench/sram_chip_model.sv
bench/sram_checker.sv
bench/sram_controller_tb.sv

// File: Makefile
TOP = sram_controller_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		-f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
